// File: rv32i_core.f
design/rv32_isa_pkg.sv
design/core_cfg_pkg.sv
design/core_ifs.sv
design/inst_fetch.sv
design/decode.sv
design/regfile.sv
design/execute.sv
design/rv32i_core.sv
test/rv32i_core_chk.sv
test/rv32i_core_tb.sv

// File: Bender.yml
package:
  name: rv32i_core

sources:
  - design/rv32_isa_pkg.sv
  - design/core_cfg_pkg.sv
  - design/core_ifs.sv
  - design/inst_fetch.sv
  - design/decode.sv
  - design/regfile.sv
  - design/execute.sv
  - design/rv32i_core.sv
  - target: test
    files:
      - test/rv32i_core_chk.sv
      - test/rv32i_core_tb.sv

// File: test/rv32i_core_tb.sv
// testbench for rv32i_core
// clock and reset, AXI read slave with random latency, program image,
// fetch order and final register checks

`timescale 1ns/1ps

module rv32i_core_tb;

    localparam int          PROG_WORDS = 18;
    localparam logic [31:0] END_ADDR   = 32'd64;
    localparam int          RUN_LIMIT  = 2000;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        exec_en;
    logic [1:0]  stat;
    logic [31:0] pc;
    logic [4:0]  dbg_addr;
    logic [31:0] dbg_data;
    logic [31:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic        rvalid;
    logic        rready;

    logic [31:0] prog [PROG_WORDS];
    logic [31:0] exp_reg [32];
    logic [31:0] exp_addr [$];
    logic [31:0] fetched [$];
    logic [31:0] rng = 32'd61664;
    logic [31:0] r_addr;
    logic        r_pend = 1'b0;
    int          ar_cnt = -1;
    int          r_cnt = 0;
    int          end_hits = 0;

    always #20 clk = ~clk;

    rv32i_core UUT (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_exec    (exec_en),
        .o_stat    (stat),
        .o_pc      (pc),
        .i_dbg_addr(dbg_addr),
        .o_dbg_data(dbg_data),
        .o_araddr  (araddr),
        .o_arvalid (arvalid),
        .i_arready (arready),
        .i_rdata   (rdata),
        .i_rvalid  (rvalid),
        .o_rready  (rready)
    );

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // ------------------------------
    // instruction assembly
    // ------------------------------
    function automatic logic [31:0] lui_op(input logic [4:0] rd, input logic [19:0] imm);
        rv32_isa_pkg::inst_u w;
        w.u.opcode   = rv32_isa_pkg::OPC_LUI;
        w.u.rd       = rd;
        w.u.imm31_12 = imm;
        return w;
    endfunction

    function automatic logic [31:0] imm_op(input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [11:0] imm);
        rv32_isa_pkg::inst_u w;
        w.i.opcode = rv32_isa_pkg::OPC_OP_IMM;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.rs1    = rs1;
        w.i.imm    = imm;
        return w;
    endfunction

    function automatic logic [31:0] reg_op(input logic [2:0] f3, input logic [6:0] f7,
                                           input logic [4:0] rd, input logic [4:0] rs1,
                                           input logic [4:0] rs2);
        rv32_isa_pkg::inst_u w;
        w.r.opcode = rv32_isa_pkg::OPC_OP;
        w.r.funct3 = f3;
        w.r.funct7 = f7;
        w.r.rd     = rd;
        w.r.rs1    = rs1;
        w.r.rs2    = rs2;
        return w;
    endfunction

    function automatic logic [31:0] branch_op(input logic [2:0] f3, input logic [4:0] rs1,
                                              input logic [4:0] rs2, input logic [12:0] off);
        rv32_isa_pkg::inst_u w;
        w.b.opcode  = rv32_isa_pkg::OPC_BRANCH;
        w.b.funct3  = f3;
        w.b.rs1     = rs1;
        w.b.rs2     = rs2;
        w.b.imm12   = off[12];
        w.b.imm11   = off[11];
        w.b.imm10_5 = off[10:5];
        w.b.imm4_1  = off[4:1];
        return w;
    endfunction

    function automatic logic [31:0] jal_op(input logic [4:0] rd, input logic [20:0] off);
        rv32_isa_pkg::inst_u w;
        w.j.opcode   = rv32_isa_pkg::OPC_JAL;
        w.j.rd       = rd;
        w.j.imm20    = off[20];
        w.j.imm19_12 = off[19:12];
        w.j.imm11    = off[11];
        w.j.imm10_1  = off[10:1];
        return w;
    endfunction

    // ------------------------------
    // AXI read slave, 0 to 3 cycles on each channel
    // ------------------------------
    always @(negedge clk) begin
        arready = 1'b0;
        rvalid  = 1'b0;
        if (r_pend && rready) begin
            if (r_cnt == 0) begin
                rvalid = 1'b1;
                rdata  = prog[r_addr[31:2]];
                r_pend = 1'b0;
            end else begin
                r_cnt--;
            end
        end
        if (arvalid) begin
            if (ar_cnt < 0) begin
                rng    = xorshift(rng);
                ar_cnt = rng[1:0];
            end
            if (ar_cnt == 0) begin
                assert ((araddr < PROG_WORDS * 4) && (araddr[1:0] == 2'b00))
                    else stop_on_error("fetch address outside the program image");
                // fetch pc follows the program path
                if (fetched.size() < exp_addr.size()) begin
                    assert (pc == exp_addr[fetched.size()])
                        else stop_on_error($sformatf("FAIL o_pc: got %08h expected %08h",
                                                     pc, exp_addr[fetched.size()]));
                end
                // accepted at the coming rising edge
                arready = 1'b1;
                fetched.push_back(araddr);
                if (araddr == END_ADDR) begin
                    end_hits++;
                end
                r_addr = araddr;
                r_pend = 1'b1;
                rng    = xorshift(rng);
                r_cnt  = rng[1:0];
                ar_cnt = -1;
            end else begin
                ar_cnt--;
            end
        end
    end

    always @(negedge clk) begin
        if (UUT.u_chk.err_cnt != 0) begin
            stop_on_error("a protocol assertion on the fetch bus failed");
        end
    end

    initial begin
        int cyc;
        rst_n    = 1'b0;
        exec_en  = 1'b0;
        dbg_addr = '0;
        arready  = 1'b0;
        rvalid   = 1'b0;
        rdata    = '0;

        // dependent ALU chain
        prog[0]  = lui_op(5'd1, 20'h12345);
        prog[1]  = imm_op(rv32_isa_pkg::F3_ADD, 5'd1, 5'd1, 12'h678);
        prog[2]  = imm_op(rv32_isa_pkg::F3_AND, 5'd2, 5'd1, 12'h0ff);
        prog[3]  = imm_op(rv32_isa_pkg::F3_OR, 5'd3, 5'd2, 12'h700);
        prog[4]  = imm_op(rv32_isa_pkg::F3_XOR, 5'd4, 5'd3, 12'hfff);
        prog[5]  = reg_op(rv32_isa_pkg::F3_ADD, 7'h00, 5'd5, 5'd4, 5'd1);
        prog[6]  = reg_op(rv32_isa_pkg::F3_ADD, rv32_isa_pkg::F7_SUB, 5'd6, 5'd5, 5'd3);
        prog[7]  = reg_op(rv32_isa_pkg::F3_AND, 7'h00, 5'd7, 5'd6, 5'd1);
        prog[8]  = reg_op(rv32_isa_pkg::F3_OR, 7'h00, 5'd8, 5'd7, 5'd2);
        prog[9]  = reg_op(rv32_isa_pkg::F3_XOR, 7'h00, 5'd9, 5'd8, 5'd1);
        // taken beq over a marker, not-taken bne, jal over a marker
        prog[10] = branch_op(rv32_isa_pkg::F3_BEQ, 5'd2, 5'd2, 13'd8);
        prog[11] = imm_op(rv32_isa_pkg::F3_ADD, 5'd10, 5'd0, 12'h055);
        prog[12] = branch_op(rv32_isa_pkg::F3_BNE, 5'd3, 5'd3, 13'd8);
        prog[13] = imm_op(rv32_isa_pkg::F3_ADD, 5'd11, 5'd0, 12'h066);
        prog[14] = jal_op(5'd12, 21'd8);
        prog[15] = imm_op(rv32_isa_pkg::F3_ADD, 5'd13, 5'd0, 12'h077);
        prog[16] = jal_op(5'd0, 21'd0);
        prog[17] = imm_op(rv32_isa_pkg::F3_ADD, 5'd14, 5'd0, 12'h088);

        for (int k = 0; k < 32; k++) begin
            exp_reg[k] = '0;
        end
        exp_reg[1]  = {20'h12345, 12'h000} + 32'h0000_0678;
        exp_reg[2]  = exp_reg[1] & 32'h0000_00ff;
        exp_reg[3]  = exp_reg[2] | 32'h0000_0700;
        exp_reg[4]  = exp_reg[3] ^ {{20{1'b1}}, 12'hfff};
        exp_reg[5]  = exp_reg[4] + exp_reg[1];
        exp_reg[6]  = exp_reg[5] - exp_reg[3];
        exp_reg[7]  = exp_reg[6] & exp_reg[1];
        exp_reg[8]  = exp_reg[7] | exp_reg[2];
        exp_reg[9]  = exp_reg[8] ^ exp_reg[1];
        exp_reg[11] = 32'h0000_0066;
        exp_reg[12] = 32'd56 + 32'd4;

        // straight line, then each redirect fetches the next word before its target
        for (int k = 0; k < 12; k++) begin
            exp_addr.push_back(k * 4);
        end
        exp_addr.push_back(32'd48);
        exp_addr.push_back(32'd52);
        exp_addr.push_back(32'd56);
        exp_addr.push_back(32'd60);
        for (int k = 0; k < 2; k++) begin
            exp_addr.push_back(END_ADDR);
            exp_addr.push_back(END_ADDR + 32'd4);
        end
        exp_addr.push_back(END_ADDR);

        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        repeat (3) @(negedge clk);
        exec_en = 1'b1;

        cyc = 0;
        while (end_hits < 3) begin
            @(posedge clk);
            cyc++;
            if (cyc > RUN_LIMIT) begin
                stop_on_error("timeout: the program never reached its final jump");
            end
        end

        assert (fetched.size() >= exp_addr.size())
            else stop_on_error("fewer fetches recorded than the program path needs");
        for (int k = 0; k < exp_addr.size(); k++) begin
            assert (fetched[k] == exp_addr[k])
                else stop_on_error($sformatf("FAIL o_araddr fetch %0d: got %08h expected %08h",
                                             k, fetched[k], exp_addr[k]));
        end

        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            dbg_addr = r[4:0];
            #1;
            assert (dbg_data === exp_reg[r])
                else stop_on_error($sformatf("FAIL o_dbg_data x%0d: got %08h expected %08h",
                                             r, dbg_data, exp_reg[r]));
        end

        if (UUT.u_chk.err_cnt == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            stop_on_error("a protocol assertion on the fetch bus failed");
        end
    end

endmodule

// File: test/rv32i_core_chk.sv
// fetch-side protocol and reset checks
// bound into every rv32i_core instance

`timescale 1ns/1ps

module rv32i_core_chk (
    input logic                            i_clk,
    input logic                            i_rst_n,
    input logic                            i_exec,
    input logic [core_cfg_pkg::STAT_W-1:0] i_stat,
    input logic [core_cfg_pkg::ADDR_W-1:0] i_araddr,
    input logic                            i_arvalid,
    input logic                            i_arready,
    input logic                            i_rready
);

    int   err_cnt = 0;
    logic seen_exec;

    // run enable seen since reset
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            seen_exec <= 1'b0;
        end else if (i_exec) begin
            seen_exec <= 1'b1;
        end
    end

    // ------------------------------
    // reset and start
    // ------------------------------
    idle_before_run: assert property (@(posedge i_clk)
        !seen_exec |-> (!i_arvalid && !i_rready && (i_stat == '0)))
        else begin
            $error("fetch bus or status active before the run enable");
            err_cnt++;
        end

    // ------------------------------
    // read address channel
    // ------------------------------
    ar_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_arvalid && !i_arready) |=> (i_arvalid && $stable(i_araddr)))
        else begin
            $error("read request dropped or changed before acceptance");
            err_cnt++;
        end

    // a new request never overlaps an outstanding read
    single_read: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        !(i_arvalid && i_rready))
        else begin
            $error("request raised while a read is outstanding");
            err_cnt++;
        end

    wait_flag: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_arvalid || i_rready) |-> i_stat[core_cfg_pkg::STAT_FETCH_WAIT])
        else begin
            $error("fetch wait status low during a fetch");
            err_cnt++;
        end

endmodule

bind rv32i_core rv32i_core_chk u_chk (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_exec   (i_exec),
    .i_stat   (o_stat),
    .i_araddr (o_araddr),
    .i_arvalid(o_arvalid),
    .i_arready(i_arready),
    .i_rready (o_rready)
);

// File: design/rv32i_core.sv
// rv32i core top level
// fetch, decode, register file and execute, status and debug outputs

`timescale 1ns/1ps

module rv32i_core (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_exec,
    output logic [core_cfg_pkg::STAT_W-1:0] o_stat,
    output logic [core_cfg_pkg::ADDR_W-1:0] o_pc,
    input  logic [core_cfg_pkg::REG_AW-1:0] i_dbg_addr,
    output logic [core_cfg_pkg::XLEN-1:0]   o_dbg_data,
    output logic [core_cfg_pkg::ADDR_W-1:0] o_araddr,
    output logic                            o_arvalid,
    input  logic                            i_arready,
    input  logic [core_cfg_pkg::XLEN-1:0]   i_rdata,
    input  logic                            i_rvalid,
    output logic                            o_rready
);

    logic                            f_valid;
    logic [core_cfg_pkg::ADDR_W-1:0] f_pc;
    logic [core_cfg_pkg::XLEN-1:0]   f_inst;
    logic                            fetch_wait;
    logic                            redirect;
    logic [core_cfg_pkg::ADDR_W-1:0] target;
    logic                            wr_en;
    logic [core_cfg_pkg::REG_AW-1:0] wr_addr;
    logic [core_cfg_pkg::XLEN-1:0]   wr_data;

    reg_rd_if  rd_bus ();
    dec_exe_if ex_bus ();

    // ------------------------------
    // pipeline stages
    // ------------------------------
    inst_fetch u_fetch (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_exec      (i_exec),
        .i_redirect  (redirect),
        .i_target    (target),
        .o_araddr    (o_araddr),
        .o_arvalid   (o_arvalid),
        .i_arready   (i_arready),
        .i_rdata     (i_rdata),
        .i_rvalid    (i_rvalid),
        .o_rready    (o_rready),
        .o_f_valid   (f_valid),
        .o_f_pc      (f_pc),
        .o_f_inst    (f_inst),
        .o_fetch_wait(fetch_wait)
    );

    decode u_decode (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_flush  (redirect),
        .i_f_valid(f_valid),
        .i_f_pc   (f_pc),
        .i_f_inst (f_inst),
        .rd       (rd_bus.dec),
        .ex       (ex_bus.dec)
    );

    regfile u_regfile (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_wr_en   (wr_en),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .i_dbg_addr(i_dbg_addr),
        .rd        (rd_bus.rf),
        .o_dbg_data(o_dbg_data)
    );

    execute u_execute (
        .ex        (ex_bus.exe),
        .o_redirect(redirect),
        .o_target  (target),
        .o_wr_en   (wr_en),
        .o_wr_addr (wr_addr),
        .o_wr_data (wr_data)
    );

    // status and debug
    assign o_stat[core_cfg_pkg::STAT_FETCH_WAIT] = fetch_wait;
    assign o_stat[core_cfg_pkg::STAT_FLUSH]      = redirect;
    // address of the current fetch request
    assign o_pc = o_araddr;

endmodule

// File: design/execute.sv
// execute stage
// ALU, branch compare, jump/branch redirect and register write

`timescale 1ns/1ps

module execute (
    dec_exe_if.exe                          ex,
    output logic                            o_redirect,
    output logic [core_cfg_pkg::ADDR_W-1:0] o_target,
    output logic                            o_wr_en,
    output logic [core_cfg_pkg::REG_AW-1:0] o_wr_addr,
    output logic [core_cfg_pkg::XLEN-1:0]   o_wr_data
);

    logic [core_cfg_pkg::XLEN-1:0]   imm_i;
    logic [core_cfg_pkg::XLEN-1:0]   imm_u;
    logic [core_cfg_pkg::ADDR_W-1:0] imm_b;
    logic [core_cfg_pkg::ADDR_W-1:0] imm_j;
    logic                            wr;
    logic                            take;

    // ------------------------------
    // immediates
    // ------------------------------
    assign imm_i = {{20{ex.inst.i.imm[11]}}, ex.inst.i.imm};
    assign imm_u = {ex.inst.u.imm31_12, 12'b0};
    assign imm_b = {{19{ex.inst.b.imm12}}, ex.inst.b.imm12, ex.inst.b.imm11,
                    ex.inst.b.imm10_5, ex.inst.b.imm4_1, 1'b0};
    assign imm_j = {{11{ex.inst.j.imm20}}, ex.inst.j.imm20, ex.inst.j.imm19_12,
                    ex.inst.j.imm11, ex.inst.j.imm10_1, 1'b0};

    // unsupported encodings fall through as no-ops
    always_comb begin
        wr        = 1'b0;
        take      = 1'b0;
        o_target  = ex.pc + imm_b;
        o_wr_data = '0;
        case (ex.inst.r.opcode)
            rv32_isa_pkg::OPC_LUI: begin
                wr        = 1'b1;
                o_wr_data = imm_u;
            end
            rv32_isa_pkg::OPC_OP_IMM: begin
                wr = 1'b1;
                case (ex.inst.i.funct3)
                    rv32_isa_pkg::F3_ADD: o_wr_data = ex.rs1_val + imm_i;
                    rv32_isa_pkg::F3_XOR: o_wr_data = ex.rs1_val ^ imm_i;
                    rv32_isa_pkg::F3_OR:  o_wr_data = ex.rs1_val | imm_i;
                    rv32_isa_pkg::F3_AND: o_wr_data = ex.rs1_val & imm_i;
                    default:              wr = 1'b0;
                endcase
            end
            rv32_isa_pkg::OPC_OP: begin
                wr = 1'b1;
                case (ex.inst.r.funct3)
                    rv32_isa_pkg::F3_ADD: begin
                        if (ex.inst.r.funct7 == rv32_isa_pkg::F7_SUB) begin
                            o_wr_data = ex.rs1_val - ex.rs2_val;
                        end else begin
                            o_wr_data = ex.rs1_val + ex.rs2_val;
                        end
                    end
                    rv32_isa_pkg::F3_XOR: o_wr_data = ex.rs1_val ^ ex.rs2_val;
                    rv32_isa_pkg::F3_OR:  o_wr_data = ex.rs1_val | ex.rs2_val;
                    rv32_isa_pkg::F3_AND: o_wr_data = ex.rs1_val & ex.rs2_val;
                    default:              wr = 1'b0;
                endcase
            end
            rv32_isa_pkg::OPC_JAL: begin
                // link is the return address
                wr        = 1'b1;
                take      = 1'b1;
                o_target  = ex.pc + imm_j;
                o_wr_data = ex.pc + core_cfg_pkg::INST_BYTES;
            end
            rv32_isa_pkg::OPC_BRANCH: begin
                case (ex.inst.b.funct3)
                    rv32_isa_pkg::F3_BEQ: take = (ex.rs1_val == ex.rs2_val);
                    rv32_isa_pkg::F3_BNE: take = (ex.rs1_val != ex.rs2_val);
                    default:              take = 1'b0;
                endcase
            end
            default: begin
                wr = 1'b0;
            end
        endcase
    end

    assign o_redirect = ex.valid & take;
    assign o_wr_addr  = ex.inst.r.rd;
    // x0 writes are dropped here
    assign o_wr_en    = ex.valid & wr & (ex.inst.r.rd != '0);

endmodule

// File: design/regfile.sv
// integer register file
// two operand read ports, debug read port, write-through bypass

`timescale 1ns/1ps

module regfile (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_wr_en,
    input  logic [core_cfg_pkg::REG_AW-1:0] i_wr_addr,
    input  logic [core_cfg_pkg::XLEN-1:0]   i_wr_data,
    input  logic [core_cfg_pkg::REG_AW-1:0] i_dbg_addr,
    reg_rd_if.rf                            rd,
    output logic [core_cfg_pkg::XLEN-1:0]   o_dbg_data
);

    // x0 has no storage
    logic [core_cfg_pkg::XLEN-1:0] regs [1:core_cfg_pkg::NUM_REGS-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 1; i < core_cfg_pkg::NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_wr_en && (i_wr_addr != '0)) begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // same-cycle write shows up on the read side
    assign rd.rs1_data = (rd.rs1_addr == '0) ? '0 :
                         (i_wr_en && (i_wr_addr == rd.rs1_addr)) ? i_wr_data :
                         regs[rd.rs1_addr];
    assign rd.rs2_data = (rd.rs2_addr == '0) ? '0 :
                         (i_wr_en && (i_wr_addr == rd.rs2_addr)) ? i_wr_data :
                         regs[rd.rs2_addr];
    assign o_dbg_data  = (i_dbg_addr == '0) ? '0 :
                         (i_wr_en && (i_wr_addr == i_dbg_addr)) ? i_wr_data :
                         regs[i_dbg_addr];

endmodule

// File: design/decode.sv
// decode stage
// register-read request and the decode/execute pipeline register

`timescale 1ns/1ps

module decode (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_flush,
    input  logic                            i_f_valid,
    input  logic [core_cfg_pkg::ADDR_W-1:0] i_f_pc,
    input  logic [core_cfg_pkg::XLEN-1:0]   i_f_inst,
    reg_rd_if.dec                           rd,
    dec_exe_if.dec                          ex
);

    rv32_isa_pkg::inst_u f_word;

    assign f_word = i_f_inst;

    // ------------------------------
    // register read
    // ------------------------------
    // rs fields sit at the same bits in every format that has them
    assign rd.rs1_addr = f_word.r.rs1;
    assign rd.rs2_addr = f_word.r.rs2;

    // ------------------------------
    // pipeline register
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            ex.valid <= 1'b0;
        end else begin
            // a taken branch in execute kills the instruction behind it
            ex.valid <= i_f_valid & ~i_flush;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_f_valid) begin
            ex.pc      <= i_f_pc;
            ex.inst    <= f_word;
            ex.rs1_val <= rd.rs1_data;
            ex.rs2_val <= rd.rs2_data;
        end
    end

endmodule

// File: design/inst_fetch.sv
// instruction fetch
// program counter and a single-outstanding AXI read master

`timescale 1ns/1ps

module inst_fetch (
    input  logic                            i_clk,
    input  logic                            i_rst_n,
    input  logic                            i_exec,
    input  logic                            i_redirect,
    input  logic [core_cfg_pkg::ADDR_W-1:0] i_target,
    output logic [core_cfg_pkg::ADDR_W-1:0] o_araddr,
    output logic                            o_arvalid,
    input  logic                            i_arready,
    input  logic [core_cfg_pkg::XLEN-1:0]   i_rdata,
    input  logic                            i_rvalid,
    output logic                            o_rready,
    output logic                            o_f_valid,
    output logic [core_cfg_pkg::ADDR_W-1:0] o_f_pc,
    output logic [core_cfg_pkg::XLEN-1:0]   o_f_inst,
    output logic                            o_fetch_wait
);

    logic [core_cfg_pkg::ADDR_W-1:0] pc_q;
    logic [core_cfg_pkg::ADDR_W-1:0] pc_nxt;
    logic                            disc_q;
    logic                            ar_hs;
    logic                            r_hs;
    logic                            issue;

    assign ar_hs = o_arvalid & i_arready;
    assign r_hs  = o_rready & i_rvalid;

    // new request once the bus is idle or the last read is just finishing
    assign issue = i_exec & ~o_arvalid & (~o_rready | r_hs);

    // redirect wins, discarded data leaves the pc alone
    always_comb begin
        pc_nxt = pc_q;
        if (i_redirect) begin
            pc_nxt = i_target;
        end else if (r_hs && !disc_q) begin
            pc_nxt = pc_q + core_cfg_pkg::INST_BYTES;
        end
    end

    // ------------------------------
    // request / outstanding state
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc_q      <= core_cfg_pkg::RESET_PC;
            o_araddr  <= core_cfg_pkg::RESET_PC;
            o_arvalid <= 1'b0;
            o_rready  <= 1'b0;
            disc_q    <= 1'b0;
            o_f_valid <= 1'b0;
        end else begin
            pc_q <= pc_nxt;
            // araddr only moves when no request is pending
            if (issue) begin
                o_arvalid <= 1'b1;
                o_araddr  <= pc_nxt;
            end else if (ar_hs) begin
                o_arvalid <= 1'b0;
            end
            if (ar_hs) begin
                o_rready <= 1'b1;
            end else if (r_hs) begin
                o_rready <= 1'b0;
            end
            // read in flight past a redirect belongs to the old path
            if (i_redirect && (o_arvalid || (o_rready && !i_rvalid))) begin
                disc_q <= 1'b1;
            end else if (r_hs) begin
                disc_q <= 1'b0;
            end
            o_f_valid <= r_hs & ~disc_q & ~i_redirect;
        end
    end

    always_ff @(posedge i_clk) begin
        if (r_hs) begin
            o_f_pc   <= o_araddr;
            o_f_inst <= i_rdata;
        end
    end

    assign o_fetch_wait = o_arvalid | o_rready;

endmodule

// File: design/core_ifs.sv
// stage interfaces
// reg_rd_if: decode to register file read ports
// dec_exe_if: decode pipeline register to execute

`timescale 1ns/1ps

interface reg_rd_if;
    logic [core_cfg_pkg::REG_AW-1:0] rs1_addr;
    logic [core_cfg_pkg::REG_AW-1:0] rs2_addr;
    logic [core_cfg_pkg::XLEN-1:0]   rs1_data;
    logic [core_cfg_pkg::XLEN-1:0]   rs2_data;

    modport dec (output rs1_addr, output rs2_addr, input rs1_data, input rs2_data);
    modport rf  (input rs1_addr, input rs2_addr, output rs1_data, output rs2_data);
endinterface

interface dec_exe_if;
    logic                            valid;
    logic [core_cfg_pkg::ADDR_W-1:0] pc;
    rv32_isa_pkg::inst_u             inst;
    logic [core_cfg_pkg::XLEN-1:0]   rs1_val;
    logic [core_cfg_pkg::XLEN-1:0]   rs2_val;

    // rd comes out of inst on the execute side
    modport dec (output valid, output pc, output inst, output rs1_val, output rs2_val);
    modport exe (input valid, input pc, input inst, input rs1_val, input rs2_val);
endinterface

// File: design/core_cfg_pkg.sv
// core configuration
// data/address widths, register file size, reset vector, status bits

package core_cfg_pkg;

    localparam int XLEN     = 32;
    localparam int ADDR_W   = 32;
    localparam int REG_AW   = 5;
    localparam int NUM_REGS = 32;

    // first fetch address out of reset
    localparam logic [ADDR_W-1:0] RESET_PC = '0;

    // pc step per instruction
    localparam logic [ADDR_W-1:0] INST_BYTES = 4;

    // ------------------------------
    // status word layout
    // ------------------------------
    localparam int STAT_W          = 2;
    localparam int STAT_FETCH_WAIT = 0;
    localparam int STAT_FLUSH      = 1;

endpackage

// File: design/rv32_isa_pkg.sv
// rv32i subset encodings
// opcodes, funct3/funct7 codes and the instruction word views

package rv32_isa_pkg;

    // ------------------------------
    // major opcodes
    // ------------------------------
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    // function codes
    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [6:0] F7_SUB = 7'b0100000;

    // ------------------------------
    // instruction formats
    // ------------------------------
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    // branch offset is scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm31_12;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // one word, five ways to read it
    typedef union packed {
        r_type_t r;
        i_type_t i;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } inst_u;

endpackage
